// File: include/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// core address and line data
`define DC_ADDR_W     64
`define DC_DATA_W     64

// direct-mapped geometry, one word per line
`define DC_OFFSET_W   3
`define DC_NUM_SETS   16
`define DC_INDEX_W    4

// tag covers address bits up to 31 only
`define DC_TAG_W      25

// miss queue depth, also the credit count after reset
`define DC_MISS_DEPTH 4

// memory bus tag, zero means no tag
`define DC_MEM_TAG_W  4

`endif

// File: rtl/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

  // full byte address or line address with offset cleared
  typedef logic [`DC_ADDR_W-1:0] line_addr_t;

  typedef logic [`DC_INDEX_W-1:0] set_index_t;
  typedef logic [`DC_TAG_W-1:0]   line_tag_t;

  // one stored line
  typedef struct packed {
    logic                  valid;
    line_tag_t             tag;
    logic [`DC_DATA_W-1:0] data;
  } cache_line_t;

  // address split helpers
  function automatic set_index_t addr_index(input line_addr_t addr);
    return addr[`DC_OFFSET_W +: `DC_INDEX_W];
  endfunction

  function automatic line_tag_t addr_tag(input line_addr_t addr);
    return addr[`DC_OFFSET_W + `DC_INDEX_W +: `DC_TAG_W];
  endfunction

  function automatic line_addr_t addr_line(input line_addr_t addr);
    return {addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
  endfunction

endpackage

// File: rtl/mem_bus_pkg.sv
`include "dcache_defines.svh"

package mem_bus_pkg;

  // bus command driven by the cache
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_cmd_t;

  // transaction tag handed out by memory
  typedef logic [`DC_MEM_TAG_W-1:0] mem_tag_t;

  //////////////////////////////////////////////////////////////////////
  // miss queue entry
  //////////////////////////////////////////////////////////////////////

  // line   aligned line address of the miss
  // mem_tag tag from memory once the command is accepted
  // sent   set on acceptance, cleared when the data comes back
  typedef struct packed {
    dcache_pkg::line_addr_t line;
    mem_tag_t               mem_tag;
    logic                   sent;
  } miss_entry_t;

endpackage

// File: rtl/dcache_ifs.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

// read port of the line store
interface line_read_if;
  import dcache_pkg::*;

  logic                  rd_en;
  set_index_t            index;
  // returned one cycle after rd_en
  logic                  valid;
  line_tag_t             tag;
  logic [`DC_DATA_W-1:0] data;

  modport requester (
    output rd_en, index,
    input  valid, tag, data
  );

  modport store (
    input  rd_en, index,
    output valid, tag, data
  );
endinterface

// refill write port, whole line per write
interface refill_if;
  import dcache_pkg::*;

  logic                  wr_en;
  set_index_t            index;
  line_tag_t             tag;
  logic [`DC_DATA_W-1:0] data;

  modport writer (
    output wr_en, index, tag, data
  );

  modport store (
    input  wr_en, index, tag, data
  );
endinterface

// File: rtl/line_store.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module line_store (
  input logic        clock,
  input logic        reset,
  line_read_if.store rd,
  refill_if.store    wr
);
  import dcache_pkg::*;

  cache_line_t lines [`DC_NUM_SETS];
  cache_line_t rd_line;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // reset only invalidates, tag and data keep whatever they held
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DC_NUM_SETS; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (wr.wr_en) begin
      // refill replaces the full line
      lines[wr.index] <= '{valid: 1'b1, tag: wr.tag, data: wr.data};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // registered read
  // a refill to the same set in the same cycle is not seen yet
  always_ff @(posedge clock) begin
    if (rd.rd_en) begin
      rd_line <= lines[rd.index];
    end
  end

  assign rd.valid = rd_line.valid;
  assign rd.tag   = rd_line.tag;
  assign rd.data  = rd_line.data;

endmodule

// File: rtl/load_port.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module load_port (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   rd_en,
  input  dcache_pkg::line_addr_t rd_addr,
  input  logic                   credit_return,
  output logic                   ready,
  output logic                   rd_valid,
  output logic [`DC_DATA_W-1:0]  rd_data,
  output logic                   miss_push,
  output dcache_pkg::line_addr_t miss_line,
  line_read_if.requester         store
);
  import dcache_pkg::*;

  localparam int CNT_W = $clog2(`DC_MISS_DEPTH + 1);

  logic [CNT_W-1:0] credits;
  logic             accept;
  logic             hit;

  // load in flight, waiting for the store read
  logic             pend_valid;
  line_tag_t        pend_tag;
  line_addr_t       pend_line;

  //////////////////////////////////////////////////////////////////////
  // acceptance and store read
  //////////////////////////////////////////////////////////////////////

  assign ready  = (credits != '0);
  assign accept = rd_en && ready;

  assign store.rd_en = accept;
  assign store.index = addr_index(rd_addr);

  always_ff @(posedge clock) begin
    if (accept) begin
      pend_tag  <= addr_tag(rd_addr);
      pend_line <= addr_line(rd_addr);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tag compare, one cycle after acceptance
  //////////////////////////////////////////////////////////////////////

  assign hit = pend_valid && store.valid && (store.tag == pend_tag);

  assign rd_valid = hit;
  assign rd_data  = store.data;

  // every load that does not hit goes to the miss queue
  assign miss_push = pend_valid && !hit;
  assign miss_line = pend_line;

  //////////////////////////////////////////////////////////////////////
  // credits
  //////////////////////////////////////////////////////////////////////

  // a credit is held from acceptance on, so two loads in a row
  // can never push into a queue with one free slot
  // the push consumes the held credit, a hit hands it back
  always_ff @(posedge clock) begin
    if (reset) begin
      credits    <= CNT_W'(`DC_MISS_DEPTH);
      pend_valid <= 1'b0;
    end else begin
      credits    <= credits - CNT_W'(accept) + CNT_W'(hit) + CNT_W'(credit_return);
      pend_valid <= accept;
    end
  end

endmodule

// File: rtl/miss_queue.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module miss_queue (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   miss_push,
  input  dcache_pkg::line_addr_t miss_line,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  logic [`DC_DATA_W-1:0]  mem_data,
  input  mem_bus_pkg::mem_tag_t  mem_tag,
  output logic                   credit_return,
  output mem_bus_pkg::bus_cmd_t  mem_command,
  output dcache_pkg::line_addr_t mem_addr,
  output logic                   miss_valid,
  output dcache_pkg::line_addr_t miss_addr,
  output logic [`DC_DATA_W-1:0]  miss_data,
  refill_if.writer               refill
);
  import dcache_pkg::*;
  import mem_bus_pkg::*;

  localparam int PTR_W = $clog2(`DC_MISS_DEPTH);

  miss_entry_t entries [`DC_MISS_DEPTH];

  // tail and send carry a wrap bit so a full queue of unsent
  // entries is told apart from an empty one
  logic [PTR_W:0]   tail_ptr;
  logic [PTR_W:0]   send_ptr;
  logic [PTR_W-1:0] wait_ptr;

  logic [PTR_W-1:0] tail_idx;
  logic [PTR_W-1:0] send_idx;

  miss_entry_t send_entry;
  miss_entry_t wait_entry;

  logic has_unsent;
  logic cmd_taken;
  logic tag_match;

  // refill stage, one cycle after the tag match
  logic                  fill_valid;
  line_addr_t            fill_line;
  logic [`DC_DATA_W-1:0] fill_data;

  assign tail_idx = tail_ptr[PTR_W-1:0];
  assign send_idx = send_ptr[PTR_W-1:0];

  assign send_entry = entries[send_idx];
  assign wait_entry = entries[wait_ptr];

  //////////////////////////////////////////////////////////////////////
  // bus command issue
  //////////////////////////////////////////////////////////////////////

  assign has_unsent = (send_ptr != tail_ptr);

  // command held until memory answers with a nonzero tag
  assign mem_command = has_unsent ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = send_entry.line;
  assign cmd_taken   = has_unsent && (mem_response != '0);

  // data returns in order, so only the oldest waiting entry is checked
  assign tag_match = wait_entry.sent && (mem_tag != '0) && (wait_entry.mem_tag == mem_tag);

  //////////////////////////////////////////////////////////////////////
  // queue state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DC_MISS_DEPTH; i++) begin
        entries[i].sent <= 1'b0;
      end
      tail_ptr <= '0;
      send_ptr <= '0;
      wait_ptr <= '0;
    end else begin
      if (miss_push) begin
        entries[tail_idx] <= '{line: miss_line, mem_tag: '0, sent: 1'b0};
        tail_ptr          <= tail_ptr + 1'b1;
      end
      if (cmd_taken) begin
        entries[send_idx].mem_tag <= mem_response;
        entries[send_idx].sent    <= 1'b1;
        send_ptr                  <= send_ptr + 1'b1;
      end
      // clearing sent keeps a stale tag in a free slot from matching
      if (tag_match) begin
        entries[wait_ptr].sent <= 1'b0;
        wait_ptr               <= wait_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // refill and miss response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= tag_match;
    end
  end

  // line address is captured here since wait_ptr already moved on
  always_ff @(posedge clock) begin
    if (tag_match) begin
      fill_line <= wait_entry.line;
      fill_data <= mem_data;
    end
  end

  assign refill.wr_en = fill_valid;
  assign refill.index = addr_index(fill_line);
  assign refill.tag   = addr_tag(fill_line);
  assign refill.data  = fill_data;

  assign miss_valid = fill_valid;
  assign miss_addr  = fill_line;
  assign miss_data  = fill_data;

  // entry retires with the refill write
  assign credit_return = fill_valid;

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_top (
  input  logic                   clock,
  input  logic                   reset,

  // core load port
  input  logic                   rd_en,
  input  dcache_pkg::line_addr_t rd_addr,
  output logic                   ready,
  output logic                   rd_valid,
  output logic [`DC_DATA_W-1:0]  rd_data,
  output logic                   miss_valid,
  output dcache_pkg::line_addr_t miss_addr,
  output logic [`DC_DATA_W-1:0]  miss_data,

  // memory bus
  output mem_bus_pkg::bus_cmd_t  mem_command,
  output dcache_pkg::line_addr_t mem_addr,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  logic [`DC_DATA_W-1:0]  mem_data,
  input  mem_bus_pkg::mem_tag_t  mem_tag
);
  import dcache_pkg::*;

  // miss channel between the two halves
  logic       miss_push;
  line_addr_t miss_line;
  logic       credit_return;

  line_read_if rd_bus ();
  refill_if    fill_bus ();

  line_store u_line_store (
    .clock (clock),
    .reset (reset),
    .rd    (rd_bus.store),
    .wr    (fill_bus.store)
  );

  load_port u_load_port (
    .clock         (clock),
    .reset         (reset),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .credit_return (credit_return),
    .ready         (ready),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .miss_push     (miss_push),
    .miss_line     (miss_line),
    .store         (rd_bus.requester)
  );

  miss_queue u_miss_queue (
    .clock         (clock),
    .reset         (reset),
    .miss_push     (miss_push),
    .miss_line     (miss_line),
    .mem_response  (mem_response),
    .mem_data      (mem_data),
    .mem_tag       (mem_tag),
    .credit_return (credit_return),
    .mem_command   (mem_command),
    .mem_addr      (mem_addr),
    .miss_valid    (miss_valid),
    .miss_addr     (miss_addr),
    .miss_data     (miss_data),
    .refill        (fill_bus.writer)
  );

endmodule

// File: test/tb_mem_model.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module tb_mem_model (
  input  logic                   clock,
  input  logic                   reset,
  input  mem_bus_pkg::bus_cmd_t  mem_command,
  input  dcache_pkg::line_addr_t mem_addr,
  input  logic                   refuse_set,
  input  logic [7:0]             refuse_count,
  output mem_bus_pkg::mem_tag_t  mem_response,
  output logic [`DC_DATA_W-1:0]  mem_data,
  output mem_bus_pkg::mem_tag_t  mem_tag
);
  import dcache_pkg::*;
  import mem_bus_pkg::*;

  localparam int LATENCY = 6;

  int         cycle;
  logic [7:0] refuse_left;
  mem_tag_t   next_tag;

  // accepted loads waiting to return, oldest first
  int                    due_q [$];
  mem_tag_t              tag_q [$];
  logic [`DC_DATA_W-1:0] data_q [$];

  // a load is taken whenever no refusal window is open
  assign mem_response = (mem_command == BUS_LOAD && refuse_left == 8'd0) ? next_tag : '0;

  always @(posedge clock) begin
    if (reset) begin
      cycle       <= 0;
      refuse_left <= 8'd0;
      next_tag    <= 4'd1;
      mem_tag     <= '0;
      mem_data    <= '0;
      due_q.delete();
      tag_q.delete();
      data_q.delete();
    end else begin
      cycle <= cycle + 1;
      if (refuse_set) begin
        refuse_left <= refuse_count;
      end else if (refuse_left != 8'd0) begin
        refuse_left <= refuse_left - 8'd1;
      end
      if (mem_response != '0) begin
        due_q.push_back(cycle + LATENCY);
        tag_q.push_back(mem_response);
        data_q.push_back({32'hd0c0_ffee, mem_addr[31:0]});
        // tags rotate through 1..15, zero is never handed out
        next_tag <= (next_tag == 4'hf) ? 4'd1 : next_tag + 4'd1;
      end
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        mem_tag  <= tag_q.pop_front();
        mem_data <= data_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        mem_tag <= '0;
      end
    end
  end

endmodule

// File: test/tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module tb_dcache;
  import dcache_pkg::*;
  import mem_bus_pkg::*;

  localparam int PERIOD      = 40;
  localparam int NUM_ROWS    = 15;
  localparam int RAND_CYCLES = 24;
  localparam int WAIT_LIMIT  = 120;

  typedef enum logic [1:0] {MODE_SINGLE, MODE_BURST, MODE_DRAIN} row_mode_t;
  typedef enum logic [1:0] {KIND_MISS, KIND_HIT, KIND_ANY} result_kind_t;

  typedef struct packed {
    row_mode_t    mode;
    line_addr_t   addr;
    result_kind_t kind;
    logic [7:0]   refuse;
    logic         exp_ready;
  } row_t;

  logic                  clock;
  logic                  reset;
  logic                  rd_en;
  line_addr_t            rd_addr;
  logic                  ready;
  logic                  rd_valid;
  logic                  miss_valid;
  logic [`DC_DATA_W-1:0] rd_data;
  logic [`DC_DATA_W-1:0] miss_data;
  logic [`DC_DATA_W-1:0] mem_data;
  line_addr_t            miss_addr;
  line_addr_t            mem_addr;
  bus_cmd_t              mem_command;
  mem_tag_t              mem_response;
  mem_tag_t              mem_tag;
  logic                  refuse_set;
  logic [7:0]            refuse_count;

  row_t         rows [NUM_ROWS];
  line_addr_t   pend_q [$];
  result_kind_t offer_kind;
  result_kind_t last_kind;
  logic         last_accept;
  line_addr_t   last_addr;
  int           errors;
  int           accepted;
  int           results;
  int           tests_run;
  int           tests_failed;

  dcache_top u_dut (.*);

  tb_mem_model u_mem (
    .clock (clock), .reset (reset), .mem_command (mem_command), .mem_addr (mem_addr),
    .refuse_set (refuse_set), .refuse_count (refuse_count),
    .mem_response (mem_response), .mem_data (mem_data), .mem_tag (mem_tag)
  );

  always #(PERIOD / 2) clock = ~clock;

  // what the DUT took at this edge
  always @(posedge clock) begin
    last_accept <= !reset && rd_en && ready;
    last_addr   <= rd_addr;
    last_kind   <= offer_kind;
  end

  initial begin
    #((NUM_ROWS + RAND_CYCLES) * 40 * PERIOD);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_line(input string name, input line_addr_t got, input line_addr_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_data(input string name, input logic [`DC_DATA_W-1:0] got,
                              input logic [`DC_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  // memory word for a line, upper half is a fixed pattern
  function automatic logic [`DC_DATA_W-1:0] expected_word(input line_addr_t addr);
    return {32'hd0c0_ffee, addr[31:3], 3'b000};
  endfunction

  function automatic line_addr_t aligned(input line_addr_t addr);
    return {addr[`DC_ADDR_W-1:3], 3'b000};
  endfunction

  // hit decision lands one cycle after acceptance, misses finish in order
  task automatic score_cycle();
    if (last_accept) begin
      accepted++;
      if (rd_valid) begin
        if (last_kind == KIND_MISS)
          flag_error($sformatf("load to %h hit but a miss was expected", last_addr));
        compare_data("rd_data", rd_data, expected_word(last_addr));
        results++;
      end else begin
        if (last_kind == KIND_HIT)
          flag_error($sformatf("load to %h missed but a hit was expected", last_addr));
        pend_q.push_back(aligned(last_addr));
      end
    end else if (rd_valid) begin
      flag_error("rd_valid came without an accepted load");
    end
    if (miss_valid) begin
      if (pend_q.size() == 0) begin
        flag_error("miss_valid came with no miss outstanding");
      end else begin
        compare_line("miss_addr", miss_addr, pend_q[0]);
        compare_data("miss_data", miss_data, expected_word(pend_q[0]));
        void'(pend_q.pop_front());
        results++;
      end
    end
  endtask

  task automatic step();
    @(negedge clock);
    score_cycle();
  endtask

  // one spare cycle at the end so a refill is written before the next read
  task automatic wait_idle();
    int n = 0;
    while (pend_q.size() != 0 && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (pend_q.size() != 0)
      flag_error("outstanding misses did not complete in time");
    step();
  endtask

  task automatic offer_load(input line_addr_t addr, input result_kind_t kind);
    int n = 0;
    rd_en      = 1'b1;
    rd_addr    = addr;
    offer_kind = kind;
    do begin
      step();
      n++;
    end while (!last_accept && n < WAIT_LIMIT);
    rd_en = 1'b0;
    if (!last_accept)
      flag_error($sformatf("load to %h was never accepted", addr));
  endtask

  task automatic report_test(input string name, input int mark);
    tests_run++;
    if (errors != mark)
      tests_failed++;
    $display("%-28s %s (%0d errors)", name, (errors == mark) ? "ok" : "error", errors - mark);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic set_row(input int idx, input row_mode_t m, input line_addr_t a,
                         input result_kind_t k, input logic [7:0] r, input logic e);
    rows[idx] = '{mode: m, addr: a, kind: k, refuse: r, exp_ready: e};
  endtask

  task automatic load_table();
    // cold line, then hits on it, upper address bits are not part of the tag
    set_row(0, MODE_SINGLE, 64'h0000_0000_0000_012d, KIND_MISS, 8'd0, 1'b1);
    set_row(1, MODE_SINGLE, 64'h0000_0000_0000_012d, KIND_HIT, 8'd0, 1'b1);
    set_row(2, MODE_SINGLE, 64'h0000_0000_0000_0128, KIND_HIT, 8'd0, 1'b1);
    set_row(3, MODE_SINGLE, 64'hffff_ffff_0000_012f, KIND_HIT, 8'd0, 1'b1);
    // two lines fighting over set 8
    set_row(4, MODE_SINGLE, 64'h0000_0000_0000_1040, KIND_MISS, 8'd0, 1'b1);
    set_row(5, MODE_SINGLE, 64'h0000_0000_0000_2040, KIND_MISS, 8'd0, 1'b1);
    set_row(6, MODE_SINGLE, 64'h0000_0000_0000_1044, KIND_MISS, 8'd0, 1'b1);
    set_row(7, MODE_SINGLE, 64'h0000_0000_0000_2047, KIND_MISS, 8'd0, 1'b1);
    // refusing memory fills the queue, the fifth load finds ready low
    set_row(8, MODE_BURST, 64'h0000_0000_0000_0500, KIND_MISS, 8'd30, 1'b1);
    set_row(9, MODE_BURST, 64'h0000_0000_0000_0608, KIND_MISS, 8'd0, 1'b1);
    set_row(10, MODE_BURST, 64'h0000_0000_0000_0710, KIND_MISS, 8'd0, 1'b1);
    set_row(11, MODE_BURST, 64'h0000_0000_0000_0818, KIND_MISS, 8'd0, 1'b1);
    set_row(12, MODE_BURST, 64'h0000_0000_0000_0920, KIND_ANY, 8'd0, 1'b0);
    set_row(13, MODE_DRAIN, 64'h0, KIND_ANY, 8'd0, 1'b1);
    set_row(14, MODE_SINGLE, 64'h0000_0000_0000_0920, KIND_MISS, 8'd0, 1'b1);
  endtask

  initial begin
    int          mark;
    logic [31:0] pick;
    void'($urandom(32'h0cc9_a159));
    clock        = 1'b0;
    reset        = 1'b1;
    rd_en        = 1'b0;
    rd_addr      = '0;
    offer_kind   = KIND_ANY;
    refuse_set   = 1'b0;
    refuse_count = 8'd0;
    errors       = 0;
    accepted     = 0;
    results      = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_table();

    repeat (16) step();
    reset = 1'b0;
    step();
    mark = errors;
    compare_bit("ready", ready, 1'b1);
    compare_bit("rd_valid", rd_valid, 1'b0);
    compare_bit("miss_valid", miss_valid, 1'b0);
    compare_bit("mem_command is BUS_NONE", mem_command == BUS_NONE, 1'b1);
    report_test("reset state", mark);

    foreach (rows[i]) begin
      mark = errors;
      if (rows[i].refuse != 8'd0) begin
        refuse_set   = 1'b1;
        refuse_count = rows[i].refuse;
        step();
        refuse_set = 1'b0;
      end
      case (rows[i].mode)
        MODE_SINGLE: begin
          offer_load(rows[i].addr, rows[i].kind);
          wait_idle();
        end
        MODE_BURST: begin
          compare_bit("ready", ready, rows[i].exp_ready);
          rd_en      = 1'b1;
          rd_addr    = rows[i].addr;
          offer_kind = rows[i].kind;
          step();
          rd_en = 1'b0;
        end
        default: wait_idle();
      endcase
      report_test($sformatf("row %0d addr %h", i, rows[i].addr), mark);
    end

    // random loads over 4 sets with 2 tags each
    mark = errors;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      pick       = $urandom;
      rd_en      = ready;
      rd_addr    = 64'h4000 | line_addr_t'({pick[2], 8'h00, pick[1:0], pick[5:3]});
      offer_kind = KIND_ANY;
      step();
    end
    rd_en = 1'b0;
    wait_idle();
    if (accepted != results)
      flag_error($sformatf("%0d loads accepted but %0d results seen", accepted, results));
    report_test("random loads", mark);

    $display("tests %0d, failing %0d, errors %0d, loads %0d, results %0d",
             tests_run, tests_failed, errors, accepted, results);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: dcache.f
+incdir+include
rtl/dcache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/dcache_ifs.sv
rtl/line_store.sv
rtl/load_port.sv
rtl/miss_queue.sv
rtl/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// File: Makefile
TOP   := tb_dcache
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f dcache.f --top-module $(TOP) -Mdir $(BUILD) -o sim

run: compile
	./$(BUILD)/sim | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf $(BUILD) sim.log
